/* include/rou_settings.svh */
`ifndef ROU_SETTINGS_SVH
`define ROU_SETTINGS_SVH

// payload word and AXI data bus
`define ROU_DWID 128

// byte address
`define ROU_AWID 32

// byte count field holds bytes minus one
`define ROU_BWID 4

`define ROU_TWID 5

// 4 entries per queue
`define ROU_FIFO_DEPTH_LOG2 2

`endif

/* list.f */
+incdir+include
rtl/rou_msg_pkg.sv
rtl/rou_axi_pkg.sv
rtl/rou_sync_fifo.sv
rtl/rou_bridge_regs.sv
rtl/rou_axi_write.sv
rtl/rou_axi_read.sv
rtl/rou_axi_master.sv
verification/rou_axi_mem_model.sv
verification/tb_rou_axi_master.sv

/* rtl/rou_axi_master.sv */
`timescale 1ns/1ns
`include "rou_settings.svh"

module rou_axi_master import rou_msg_pkg::*, rou_axi_pkg::*; (
     input  logic                   clk
    ,input  logic                   rst_n
    ,input  logic                   msg_in_valid
    ,input  rou_cmd_t               msg_in_cmd
    ,input  logic [`ROU_TWID-1:0]   msg_in_tags
    ,input  logic [`ROU_BWID-1:0]   msg_in_bytes
    ,input  logic [`ROU_AWID-1:0]   msg_in_addr
    ,input  logic [`ROU_DWID-1:0]   msg_in_data
    ,output logic                   msg_in_ack
    ,output logic                   msg_out_valid
    ,output rou_cmd_t               msg_out_cmd
    ,output logic [`ROU_TWID-1:0]   msg_out_tags
    ,output logic [`ROU_BWID-1:0]   msg_out_bytes
    ,output logic [`ROU_AWID-1:0]   msg_out_addr
    ,output logic [`ROU_DWID-1:0]   msg_out_data
    ,input  logic                   msg_out_ack
    ,input  logic                   cfg_wr
    ,input  logic [1:0]             cfg_sel
    ,input  logic [31:0]            cfg_wdata
    ,output logic [31:0]            cfg_rdata
    ,output logic [3:0]             awid
    ,output logic [`ROU_AWID-1:0]   awaddr
    ,output logic [7:0]             awlen
    ,output logic [2:0]             awsize
    ,output rou_axi_burst_t         awburst
    ,output logic                   awvalid
    ,input  logic                   awready
    ,output logic [`ROU_DWID-1:0]   wdata
    ,output logic [`ROU_DWID/8-1:0] wstrb
    ,output logic                   wlast
    ,output logic                   wvalid
    ,input  logic                   wready
    ,input  logic [3:0]             bid
    ,input  rou_axi_resp_t          bresp
    ,input  logic                   bvalid
    ,output logic                   bready
    ,output logic [3:0]             arid
    ,output logic [`ROU_AWID-1:0]   araddr
    ,output logic [7:0]             arlen
    ,output logic [2:0]             arsize
    ,output rou_axi_burst_t         arburst
    ,output logic                   arvalid
    ,input  logic                   arready
    ,input  logic [3:0]             rid
    ,input  logic [`ROU_DWID-1:0]   rdata
    ,input  rou_axi_resp_t          rresp
    ,input  logic                   rlast
    ,input  logic                   rvalid
    ,output logic                   rready
);

    rou_payload_u         payload;
    logic                 accept;
    logic                 wr_full, rd_full;
    logic                 back_valid, back_pop;
    logic [`ROU_DWID-1:0] back_data;
    logic [`ROU_AWID-1:0] back_addr;
    logic [`ROU_AWID-1:0] base_address;
    logic                 b_err, r_err;

    assign payload    = msg_in_data;
    assign msg_in_ack = !wr_full && !rd_full;  // room in every queue
    assign accept     = msg_in_valid && msg_in_ack;

    rou_bridge_regs regs_i (
         .clk(clk), .rst_n(rst_n)
        ,.cfg_wr(cfg_wr), .cfg_sel(cfg_sel), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
        ,.b_err(b_err), .r_err(r_err), .base_address(base_address)
    );

    rou_axi_write write_i (
         .clk(clk), .rst_n(rst_n)
        ,.wr_push(accept && (msg_in_cmd == CMD_WRITE))
        ,.wr_addr(msg_in_addr), .wr_bytes(msg_in_bytes), .wr_data(payload.wr_data)
        ,.base_address(base_address), .wr_full(wr_full)
        ,.awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize)
        ,.awburst(awburst), .awvalid(awvalid), .awready(awready)
        ,.wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready)
        ,.bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready), .b_err(b_err)
    );

    rou_axi_read read_i (
         .clk(clk), .rst_n(rst_n)
        ,.rd_push(accept && (msg_in_cmd == CMD_READ))
        ,.rd_addr(msg_in_addr), .rd_tags(msg_in_tags), .rd_bytes(msg_in_bytes)
        ,.rd_len_hi(payload.rd.length_hi), .rd_return_addr(payload.rd.return_addr)
        ,.rd_full(rd_full)
        ,.arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize)
        ,.arburst(arburst), .arvalid(arvalid), .arready(arready)
        ,.rid(rid), .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid)
        ,.rready(rready)
        ,.back_pop(back_pop), .back_valid(back_valid)
        ,.back_data(back_data), .back_addr(back_addr), .r_err(r_err)
    );

    // one response message per returned beat
    assign back_pop      = msg_out_ack && back_valid;
    assign msg_out_valid = back_valid;
    assign msg_out_cmd   = back_valid ? CMD_RESP : CMD_NONE;
    assign msg_out_tags  = '0;
    assign msg_out_bytes = 4'hf;    // full 16-byte word
    assign msg_out_addr  = back_addr;
    assign msg_out_data  = back_data;

endmodule

/* rtl/rou_axi_pkg.sv */
package rou_axi_pkg;

    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'd0,
        AXI_BURST_INCR  = 2'd1
    } rou_axi_burst_t;

    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'd0,
        AXI_RESP_EXOKAY = 2'd1,
        AXI_RESP_SLVERR = 2'd2,
        AXI_RESP_DECERR = 2'd3
    } rou_axi_resp_t;

    // single ID on both directions
    localparam logic [3:0] ROU_AXI_ID = 4'd3;

    // 16 bytes per beat
    localparam logic [2:0] ROU_AXI_SIZE16 = 3'd4;

endpackage

/* rtl/rou_axi_read.sv */
`timescale 1ns/1ns
`include "rou_settings.svh"

module rou_axi_read import rou_axi_pkg::*; (
     input  logic                 clk
    ,input  logic                 rst_n
    ,input  logic                 rd_push
    ,input  logic [`ROU_AWID-1:0] rd_addr
    ,input  logic [`ROU_TWID-1:0] rd_tags
    ,input  logic [`ROU_BWID-1:0] rd_bytes
    ,input  logic [15:0]          rd_len_hi
    ,input  logic [`ROU_AWID-1:0] rd_return_addr
    ,output logic                 rd_full
    ,output logic [3:0]           arid
    ,output logic [`ROU_AWID-1:0] araddr
    ,output logic [7:0]           arlen
    ,output logic [2:0]           arsize
    ,output rou_axi_burst_t       arburst
    ,output logic                 arvalid
    ,input  logic                 arready
    ,input  logic [3:0]           rid
    ,input  logic [`ROU_DWID-1:0] rdata
    ,input  rou_axi_resp_t        rresp
    ,input  logic                 rlast
    ,input  logic                 rvalid
    ,output logic                 rready
    ,input  logic                 back_pop
    ,output logic                 back_valid
    ,output logic [`ROU_DWID-1:0] back_data
    ,output logic [`ROU_AWID-1:0] back_addr
    ,output logic                 r_err
);

    localparam int REQ_W  = 16 + `ROU_TWID + `ROU_BWID + 2 * `ROU_AWID;
    localparam int BACK_W = `ROU_DWID + `ROU_AWID;

    localparam logic AR_IDLE  = 1'b0;
    localparam logic AR_BURST = 1'b1;

    logic                 req_empty;
    logic                 back_full, back_empty;
    logic [15:0]          req_len_hi;
    logic [`ROU_TWID-1:0] req_tags;
    logic [`ROU_BWID-1:0] req_bytes;
    logic [`ROU_AWID-1:0] req_addr;
    logic [`ROU_AWID-1:0] req_ret;
    logic [20:0]          req_len;
    logic [16:0]          req_beats;
    logic                 ar_state;
    logic [`ROU_AWID-1:0] ret_addr;
    logic                 ret_step;
    logic                 ar_fire;
    logic                 r_beat;

    rou_sync_fifo #(.WIDTH(REQ_W), .DEPTH_LOG2(`ROU_FIFO_DEPTH_LOG2)) req_q (
         .clk(clk), .rst_n(rst_n)
        ,.push(rd_push)
        ,.push_data({rd_len_hi, rd_tags, rd_bytes, rd_addr, rd_return_addr})
        ,.pop(ar_fire)
        ,.pop_data({req_len_hi, req_tags, req_bytes, req_addr, req_ret})
        ,.full(rd_full), .empty(req_empty)
    );

    // byte count field is length minus one
    assign req_len   = {1'b0, req_len_hi, req_bytes} + 21'd1;
    assign req_beats = req_len[20:4] + (req_len[3:0] != 4'd0);

    assign arvalid = (ar_state == AR_IDLE) && !req_empty;
    assign ar_fire = arvalid && arready;
    assign arid    = ROU_AXI_ID;
    assign araddr  = req_addr;
    assign arlen   = req_beats[7:0] - 8'd1;
    assign arsize  = ROU_AXI_SIZE16;
    assign arburst = req_tags[1] ? AXI_BURST_FIXED : AXI_BURST_INCR;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_state <= AR_IDLE;
        end else begin
            case (ar_state)
                AR_IDLE:  if (ar_fire) ar_state <= AR_BURST;
                AR_BURST: if (r_beat && rlast) ar_state <= AR_IDLE;
                default:  ar_state <= AR_IDLE;
            endcase
        end
    end

    // return address of the next beat
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            ret_addr <= req_ret;
            ret_step <= req_tags[0];
        end else if (r_beat && ret_step) begin
            ret_addr <= ret_addr + 32'd16;
        end
    end

    assign rready = !back_full;
    assign r_beat = rvalid && rready;
    assign r_err  = r_beat && (rresp != AXI_RESP_OKAY);

    rou_sync_fifo #(.WIDTH(BACK_W), .DEPTH_LOG2(`ROU_FIFO_DEPTH_LOG2)) back_q (
         .clk(clk), .rst_n(rst_n)
        ,.push(r_beat), .push_data({rdata, ret_addr})
        ,.pop(back_pop), .pop_data({back_data, back_addr})
        ,.full(back_full), .empty(back_empty)
    );

    assign back_valid = !back_empty;

    // slave answers only the one open burst
    r_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> (ar_state == AR_BURST) && (rid == ROU_AXI_ID))
        else $error("read data outside an open burst");

endmodule

/* rtl/rou_axi_write.sv */
`timescale 1ns/1ns
`include "rou_settings.svh"

module rou_axi_write import rou_axi_pkg::*; (
     input  logic                   clk
    ,input  logic                   rst_n
    ,input  logic                   wr_push
    ,input  logic [`ROU_AWID-1:0]   wr_addr
    ,input  logic [`ROU_BWID-1:0]   wr_bytes
    ,input  logic [`ROU_DWID-1:0]   wr_data
    ,input  logic [`ROU_AWID-1:0]   base_address
    ,output logic                   wr_full
    ,output logic [3:0]             awid
    ,output logic [`ROU_AWID-1:0]   awaddr
    ,output logic [7:0]             awlen
    ,output logic [2:0]             awsize
    ,output rou_axi_burst_t         awburst
    ,output logic                   awvalid
    ,input  logic                   awready
    ,output logic [`ROU_DWID-1:0]   wdata
    ,output logic [`ROU_DWID/8-1:0] wstrb
    ,output logic                   wlast
    ,output logic                   wvalid
    ,input  logic                   wready
    ,input  logic [3:0]             bid
    ,input  rou_axi_resp_t          bresp
    ,input  logic                   bvalid
    ,output logic                   bready
    ,output logic                   b_err
);

    localparam int SWID = `ROU_DWID / 8;
    localparam int DQ_W = `ROU_DWID + `ROU_BWID + 4;

    logic                 aq_full, aq_empty;
    logic                 dq_full, dq_empty;
    logic [`ROU_AWID-1:0] head_addr;
    logic [`ROU_DWID-1:0] head_data;
    logic [`ROU_BWID-1:0] head_bytes;
    logic [3:0]           head_off;
    logic [SWID:0]        strb_ones;

    rou_sync_fifo #(.WIDTH(`ROU_AWID), .DEPTH_LOG2(`ROU_FIFO_DEPTH_LOG2)) addr_q (
         .clk(clk), .rst_n(rst_n)
        ,.push(wr_push), .push_data(wr_addr)
        ,.pop(awvalid && awready), .pop_data(head_addr)
        ,.full(aq_full), .empty(aq_empty)
    );

    // data queue keeps byte count and line offset beside the payload
    rou_sync_fifo #(.WIDTH(DQ_W), .DEPTH_LOG2(`ROU_FIFO_DEPTH_LOG2)) data_q (
         .clk(clk), .rst_n(rst_n)
        ,.push(wr_push), .push_data({wr_data, wr_bytes, wr_addr[3:0]})
        ,.pop(wvalid && wready), .pop_data({head_data, head_bytes, head_off})
        ,.full(dq_full), .empty(dq_empty)
    );

    assign wr_full = aq_full || dq_full;

    assign awvalid = !aq_empty;
    assign awid    = ROU_AXI_ID;
    assign awaddr  = head_addr - base_address;
    assign awlen   = 8'd0;      // always one beat
    assign awsize  = ROU_AXI_SIZE16;
    assign awburst = AXI_BURST_INCR;

    // bytes+1 low ones, moved up to the byte lane of the offset
    assign strb_ones = ({{SWID{1'b0}}, 1'b1} << ({1'b0, head_bytes} + 5'd1)) - 1'b1;

    assign wvalid = !dq_empty;
    assign wdata  = head_data << {head_off, 3'b000};
    assign wstrb  = strb_ones[SWID-1:0] << head_off;
    assign wlast  = wvalid;

    assign bready = 1'b1;
    assign b_err  = bvalid && bready && (bresp != AXI_RESP_OKAY);

    // no line split here
    in_one_line: assert property (@(posedge clk) disable iff (!rst_n)
        wr_push |-> ({1'b0, wr_addr[3:0]} + {1'b0, wr_bytes}) <= 5'd15)
        else $error("write crosses a 16-byte line");
    b_fixed_id: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> bid == ROU_AXI_ID)
        else $error("write response with foreign id");

endmodule

/* rtl/rou_bridge_regs.sv */
`timescale 1ns/1ns
`include "rou_settings.svh"

module rou_bridge_regs (
     input  logic                 clk
    ,input  logic                 rst_n
    ,input  logic                 cfg_wr
    ,input  logic [1:0]           cfg_sel
    ,input  logic [31:0]          cfg_wdata
    ,output logic [31:0]          cfg_rdata
    ,input  logic                 b_err
    ,input  logic                 r_err
    ,output logic [`ROU_AWID-1:0] base_address
);

    localparam logic [1:0] SEL_BASE   = 2'd0;
    localparam logic [1:0] SEL_CLEAR  = 2'd1;
    localparam logic [1:0] SEL_STATUS = 2'd2;

    logic [1:0] err_flags;  // bit 0 write, bit 1 read
    logic       clear_hit;

    assign clear_hit = cfg_wr && (cfg_sel == SEL_CLEAR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_address <= '0;
            err_flags    <= 2'b00;
        end else begin
            if (cfg_wr && (cfg_sel == SEL_BASE))
                base_address <= cfg_wdata;
            // a new error in the clear cycle still sticks
            err_flags <= (clear_hit ? 2'b00 : err_flags) | {r_err, b_err};
        end
    end

    always_comb begin
        case (cfg_sel)
            SEL_BASE:   cfg_rdata = base_address;
            SEL_STATUS: cfg_rdata = {30'd0, err_flags};
            default:    cfg_rdata = 32'd0;
        endcase
    end

endmodule

/* rtl/rou_msg_pkg.sv */
`include "rou_settings.svh"

package rou_msg_pkg;

    // 2 is write on input and response on output
    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_READ  = 2'd1,
        CMD_WRITE = 2'd2
    } rou_cmd_t;

    localparam rou_cmd_t CMD_RESP = CMD_WRITE;

    // read message layout inside the payload word
    localparam int RD_LEN_HI_W = 16;
    localparam int RD_RET_W    = `ROU_AWID;
    localparam int RD_RSVD_W   = `ROU_DWID - RD_LEN_HI_W - RD_RET_W;

    typedef struct packed {
        logic [RD_RSVD_W-1:0]   rsvd;
        logic [RD_LEN_HI_W-1:0] length_hi;   // upper bits of the read length
        logic [RD_RET_W-1:0]    return_addr; // where the response messages go
    } rou_rd_view_t;

    // write messages carry plain data in the same word
    typedef union packed {
        logic [`ROU_DWID-1:0] wr_data;
        rou_rd_view_t         rd;
    } rou_payload_u;

endpackage

/* rtl/rou_sync_fifo.sv */
`timescale 1ns/1ns

module rou_sync_fifo #(
     parameter int WIDTH      = 8
    ,parameter int DEPTH_LOG2 = 2
) (
     input  logic             clk
    ,input  logic             rst_n
    ,input  logic             push
    ,input  logic [WIDTH-1:0] push_data
    ,input  logic             pop
    ,output logic [WIDTH-1:0] pop_data
    ,output logic             full
    ,output logic             empty
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    assign pop_data = mem[rd_ptr];  // head is visible before pop
    assign full     = count[DEPTH_LOG2];
    assign empty    = (count == '0);

    no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("push into a full queue");
    no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("pop from an empty queue");

endmodule

/* verification/rou_axi_mem_model.sv */
`timescale 1ns/1ns
`include "rou_settings.svh"

module rou_axi_mem_model import rou_axi_pkg::*; #(
     parameter logic [31:0] ERR_ADDR = 32'h0000_0800
) (
     input  logic                   clk
    ,input  logic [`ROU_AWID-1:0]   awaddr
    ,input  logic                   awvalid
    ,output logic                   awready
    ,input  logic [`ROU_DWID-1:0]   wdata
    ,input  logic [`ROU_DWID/8-1:0] wstrb
    ,input  logic                   wvalid
    ,output logic                   wready
    ,output logic [3:0]             bid
    ,output rou_axi_resp_t          bresp
    ,output logic                   bvalid
    ,input  logic [`ROU_AWID-1:0]   araddr
    ,input  logic [7:0]             arlen
    ,input  rou_axi_burst_t         arburst
    ,input  logic                   arvalid
    ,output logic                   arready
    ,output logic [3:0]             rid
    ,output logic [`ROU_DWID-1:0]   rdata
    ,output rou_axi_resp_t          rresp
    ,output logic                   rlast
    ,output logic                   rvalid
    ,input  logic                   rready
);

    localparam int SWID = `ROU_DWID / 8;

    logic [`ROU_DWID-1:0]      mem [256];
    logic [`ROU_AWID-1:0]      aw_q [$];
    logic [SWID+`ROU_DWID-1:0] w_q [$];
    logic                      burst_open;
    logic [`ROU_AWID-1:0]      r_addr;
    logic [7:0]                r_left;    // beats after the current one
    logic                      r_fixed;
    integer                    seed = 32'ha4f5d178;

    assign bid = ROU_AXI_ID;
    assign rid = ROU_AXI_ID;

    // every byte depends on its own address
    initial begin
        for (int i = 0; i < 256; i++)
            for (int b = 0; b < SWID; b++)
                mem[i][8*b +: 8] = 8'(i * 17 + b * 29 + 91);
    end

    initial begin
        logic                      r_hit;
        logic [`ROU_AWID-1:0]      a;
        logic [SWID+`ROU_DWID-1:0] wd;
        awready    = 1'b0;
        wready     = 1'b0;
        arready    = 1'b0;
        bvalid     = 1'b0;
        bresp      = AXI_RESP_OKAY;
        rvalid     = 1'b0;
        rlast      = 1'b0;
        rresp      = AXI_RESP_OKAY;
        rdata      = '0;
        burst_open = 1'b0;
        forever begin
            @(posedge clk);
            r_hit = rvalid && rready;
            if (awvalid && awready)
                aw_q.push_back(awaddr);
            if (wvalid && wready)
                w_q.push_back({wstrb, wdata});
            if (arvalid && arready) begin
                burst_open = 1'b1;
                r_addr     = araddr;
                r_left     = arlen;
                r_fixed    = (arburst == AXI_BURST_FIXED);
            end else if (r_hit) begin
                if (rlast) begin
                    burst_open = 1'b0;
                end else begin
                    r_left = r_left - 8'd1;
                    if (!r_fixed)
                        r_addr = r_addr + 32'd16;
                end
            end
            #2;
            bvalid = 1'b0;
            if (aw_q.size() != 0 && w_q.size() != 0) begin  // address and data paired
                a      = aw_q.pop_front();
                wd     = w_q.pop_front();
                bresp  = (a == ERR_ADDR) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
                bvalid = 1'b1;
                for (int k = 0; k < SWID; k++)
                    if (wd[`ROU_DWID + k] && a != ERR_ADDR)
                        mem[a[11:4]][8*k +: 8] = wd[8*k +: 8];
            end
            awready = ($random(seed) & 3) != 0;
            wready  = ($random(seed) & 3) != 0;
            arready = !burst_open && (($random(seed) & 3) != 0);
            if (!burst_open)
                rvalid = 1'b0;
            else if (!rvalid || r_hit)
                rvalid = ($random(seed) & 3) != 0;  // held once raised
            rdata = mem[r_addr[11:4]];
            rresp = (r_addr == ERR_ADDR) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
            rlast = (r_left == 8'd0);
        end
    end

endmodule

/* verification/tb_rou_axi_master.sv */
`timescale 1ns/1ns
`include "rou_settings.svh"

module tb_rou_axi_master import rou_msg_pkg::*, rou_axi_pkg::*;;

    typedef enum logic [2:0] {E_CFG, E_WR, E_RD, E_DRAIN, E_STAT} entry_kind_t;

    typedef struct packed {
        entry_kind_t kind;
        logic [1:0]  sel;
        logic [31:0] addr;
        logic [3:0]  bytes;
        logic [4:0]  tags;
        logic [15:0] len_hi;
        logic [31:0] ret;
        logic [7:0]  beats;
        logic [31:0] word;    // write data seed, cfg data or expected status
    } entry_t;

    localparam logic [31:0] ERR_ADDR    = 32'h0000_0800;
    localparam int          N_ENTRIES   = 22;
    localparam int          CYCLE_LIMIT = 200 * N_ENTRIES;

    entry_t stim_table [N_ENTRIES] = '{
        // kind    sel   addr           bytes  tags   len_hi return addr    beats word
        '{E_WR,    2'd0, 32'h0000_0013, 4'd4,  5'd0, 16'd0, 32'h0000_0000, 8'd0, 32'h1122_3344},
        '{E_RD,    2'd0, 32'h0000_0010, 4'd15, 5'd0, 16'd0, 32'h4000_0000, 8'd1, 32'h0},
        '{E_DRAIN, 2'd0, 32'h0,         4'd0,  5'd0, 16'd0, 32'h0,         8'd0, 32'h0},
        '{E_CFG,   2'd0, 32'h0,         4'd0,  5'd0, 16'd0, 32'h0,         8'd0, 32'h0000_1000},
        '{E_WR,    2'd0, 32'h0000_1025, 4'd7,  5'd0, 16'd0, 32'h0,         8'd0, 32'hcafe_0102},
        '{E_CFG,   2'd0, 32'h0,         4'd0,  5'd0, 16'd0, 32'h0,         8'd0, 32'h0},
        '{E_RD,    2'd0, 32'h0000_0020, 4'd15, 5'd0, 16'd0, 32'h0000_0100, 8'd1, 32'h0},
        // 84 bytes, 6 beats, stepping return address
        '{E_RD,    2'd0, 32'h0000_0040, 4'd3,  5'd1, 16'd5, 32'h8000_0000, 8'd6, 32'h0},
        // fixed burst, 48 bytes
        '{E_RD,    2'd0, 32'h0000_0060, 4'd15, 5'd2, 16'd2, 32'h0000_0180, 8'd3, 32'h0},
        '{E_RD,    2'd0, 32'h0000_0080, 4'd0,  5'd0, 16'd1, 32'h0000_0200, 8'd2, 32'h0},
        '{E_DRAIN, 2'd0, 32'h0,         4'd0,  5'd0, 16'd0, 32'h0,         8'd0, 32'h0},
        '{E_WR,    2'd0, ERR_ADDR,      4'd15, 5'd0, 16'd0, 32'h0,         8'd0, 32'hdead_beef},
        '{E_STAT,  2'd2, 32'h0,         4'd0,  5'd0, 16'd0, 32'h0,         8'd0, 32'h1},
        '{E_RD,    2'd0, ERR_ADDR,      4'd15, 5'd0, 16'd0, 32'h0000_0280, 8'd1, 32'h0},
        '{E_DRAIN, 2'd0, 32'h0,         4'd0,  5'd0, 16'd0, 32'h0,         8'd0, 32'h0},
        '{E_STAT,  2'd2, 32'h0,         4'd0,  5'd0, 16'd0, 32'h0,         8'd0, 32'h3},
        '{E_CFG,   2'd1, 32'h0,         4'd0,  5'd0, 16'd0, 32'h0,         8'd0, 32'h0},
        '{E_STAT,  2'd2, 32'h0,         4'd0,  5'd0, 16'd0, 32'h0,         8'd0, 32'h0},
        '{E_WR,    2'd0, 32'h0000_003a, 4'd3,  5'd0, 16'd0, 32'h0,         8'd0, 32'h5566_7788},
        '{E_WR,    2'd0, 32'h0000_0044, 4'd11, 5'd0, 16'd0, 32'h0,         8'd0, 32'h0bad_f00d},
        '{E_RD,    2'd0, 32'h0000_0030, 4'd15, 5'd1, 16'd1, 32'h0000_0300, 8'd2, 32'h0},
        '{E_DRAIN, 2'd0, 32'h0,         4'd0,  5'd0, 16'd0, 32'h0,         8'd0, 32'h0}
    };

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   msg_in_valid, msg_in_ack, msg_out_valid, msg_out_ack;
    rou_cmd_t               msg_in_cmd, msg_out_cmd;
    logic [`ROU_TWID-1:0]   msg_in_tags, msg_out_tags;
    logic [`ROU_BWID-1:0]   msg_in_bytes, msg_out_bytes;
    logic [`ROU_AWID-1:0]   msg_in_addr, msg_out_addr;
    logic [`ROU_DWID-1:0]   msg_in_data, msg_out_data;
    logic                   cfg_wr;
    logic [1:0]             cfg_sel;
    logic [31:0]            cfg_wdata, cfg_rdata;
    logic [3:0]             awid, bid, arid, rid;
    logic [`ROU_AWID-1:0]   awaddr, araddr;
    logic [7:0]             awlen, arlen;
    logic [2:0]             awsize, arsize;
    rou_axi_burst_t         awburst, arburst;
    logic                   awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic [`ROU_DWID-1:0]   wdata, rdata;
    logic [`ROU_DWID/8-1:0] wstrb;
    rou_axi_resp_t          bresp, rresp;
    logic                   arvalid, arready, rlast, rvalid, rready;

    logic [`ROU_DWID-1:0]   sb_mem [256];
    logic [31:0]            sb_base = '0;
    logic [`ROU_DWID-1:0]   exp_data [$];
    logic [`ROU_AWID-1:0]   exp_addr [$];
    integer                 seed = 32'ha4f5d178;
    int                     cycles = 0;
    logic                   r_taken;

    rou_axi_master dut_i (.*);

    rou_axi_mem_model #(.ERR_ADDR(ERR_ADDR)) mem_i (.*);

    always #10 clk = ~clk;

    task automatic stop_failed();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] want,
                                   input logic [127:0] got);
        $display("** Error %s: expected 0x%0h, actual 0x%0h", name, want, got);
        stop_failed();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        stop_failed();
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic send_msg(input rou_cmd_t cmd, input logic [4:0] tags, input logic [3:0] bytes,
                            input logic [31:0] addr, input logic [127:0] data);
        msg_in_valid = 1'b1;
        msg_in_cmd   = cmd;
        msg_in_tags  = tags;
        msg_in_bytes = bytes;
        msg_in_addr  = addr;
        msg_in_data  = data;
        @(posedge clk);
        assert (msg_in_ack) else report_mismatch("msg_in_ack", 1'b1, msg_in_ack);
        #2;
        msg_in_valid = 1'b0;
        msg_in_cmd   = CMD_NONE;
    endtask

    task automatic write_msg(input logic [31:0] addr, input logic [3:0] bytes,
                             input logic [31:0] word);
        logic [`ROU_DWID-1:0] data;
        logic [31:0]          local_a;
        int                   off;
        data    = {word ^ 32'h0f0f_0f0f, word + 32'd1, ~word, word};
        local_a = addr - sb_base;
        off     = addr[3:0];
        // payload moves up by the line offset, bytes+1 lanes change
        if (local_a != ERR_ADDR) begin
            for (int k = off; k <= off + bytes; k++)
                sb_mem[local_a[11:4]][8*k +: 8] = data[8*(k - off) +: 8];
        end
        send_msg(CMD_WRITE, 5'd0, bytes, addr, data);
        @(posedge clk);
        while (!bvalid)
            @(posedge clk);
        #2;
    endtask

    task automatic read_msg(input entry_t e);
        logic [31:0] line_a;
        for (int k = 0; k < e.beats; k++) begin
            line_a = e.tags[1] ? e.addr : e.addr + 32'(16 * k);
            exp_data.push_back(sb_mem[line_a[11:4]]);
            exp_addr.push_back(e.tags[0] ? e.ret + 32'(16 * k) : e.ret);
        end
        send_msg(CMD_READ, e.tags, e.bytes, e.addr, {80'd0, e.len_hi, e.ret});
    endtask

    task automatic cfg_write(input logic [1:0] sel, input logic [31:0] data);
        cfg_wr    = 1'b1;
        cfg_sel   = sel;
        cfg_wdata = data;
        if (sel == 2'd0)
            sb_base = data;
        next_cycle();
        cfg_wr = 1'b0;
    endtask

    task automatic check_status(input logic [31:0] want);
        cfg_sel = 2'd2;
        @(posedge clk);
        assert (cfg_rdata == want) else report_mismatch("cfg_rdata", want, cfg_rdata);
        #2;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT)
            report_problem($sformatf("timeout: run still busy after %0d cycles", CYCLE_LIMIT));
    end

    // fixed AXI fields, and a response message one cycle after each taken R beat
    always @(posedge clk) begin
        if (rst_n) begin
            if (r_taken) begin
                assert (msg_out_valid)
                    else report_mismatch("msg_out_valid", 1'b1, msg_out_valid);
            end
            if (awvalid) begin
                assert (awid == 4'd3) else report_mismatch("awid", 4'd3, awid);
                assert (awlen == 8'd0) else report_mismatch("awlen", 8'd0, awlen);
                assert (awsize == 3'd4) else report_mismatch("awsize", 3'd4, awsize);
                assert (awburst == 2'd1) else report_mismatch("awburst", 2'd1, awburst);
            end
            if (wvalid) begin
                assert (wlast) else report_mismatch("wlast", 1'b1, wlast);
            end
            if (arvalid) begin
                assert (arid == 4'd3) else report_mismatch("arid", 4'd3, arid);
                assert (arsize == 3'd4) else report_mismatch("arsize", 3'd4, arsize);
            end
            assert (bready) else report_mismatch("bready", 1'b1, bready);
        end
        r_taken <= rst_n && rvalid && rready;
    end

    // response sink with random gaps between pops
    initial begin
        logic [`ROU_DWID-1:0] want_d;
        logic [`ROU_AWID-1:0] want_a;
        msg_out_ack = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            if (msg_out_ack) begin
                assert (exp_data.size() != 0)
                    else report_problem("response message arrived while none was expected");
                want_d = exp_data.pop_front();
                want_a = exp_addr.pop_front();
                assert (msg_out_cmd == 2'd2) else report_mismatch("msg_out_cmd", 2'd2, msg_out_cmd);
                assert (msg_out_tags == 5'd0)
                    else report_mismatch("msg_out_tags", 5'd0, msg_out_tags);
                assert (msg_out_bytes == 4'd15)
                    else report_mismatch("msg_out_bytes", 4'd15, msg_out_bytes);
                assert (msg_out_addr == want_a)
                    else report_mismatch("msg_out_addr", want_a, msg_out_addr);
                assert (msg_out_data == want_d)
                    else report_mismatch("msg_out_data", want_d, msg_out_data);
            end
            #2;
            msg_out_ack = msg_out_valid && !msg_out_ack && (($random(seed) & 3) == 0);
        end
    end

    initial begin
        entry_t e;
        rst_n        = 1'b0;
        msg_in_valid = 1'b0;
        msg_in_cmd   = CMD_NONE;
        msg_in_tags  = '0;
        msg_in_bytes = '0;
        msg_in_addr  = '0;
        msg_in_data  = '0;
        cfg_wr       = 1'b0;
        cfg_sel      = 2'd0;
        cfg_wdata    = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < 256; i++)
            sb_mem[i] = mem_i.mem[i];   // start from the model's fill
        for (int n = 0; n < N_ENTRIES; n++) begin
            e = stim_table[n];
            case (e.kind)
                E_CFG:   cfg_write(e.sel, e.word);
                E_WR:    write_msg(e.addr, e.bytes, e.word);
                E_RD:    read_msg(e);
                E_STAT:  check_status(e.word);
                default: begin
                    while (exp_data.size() != 0)
                        next_cycle();
                end
            endcase
        end
        repeat (20) next_cycle();
        assert (!msg_out_valid) else report_mismatch("msg_out_valid", 1'b0, msg_out_valid);
        $display("Simulation PASSED");
        $finish;
    end

endmodule
